//--- Makefile
# Verilator flow for the snake game testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

obj_dir/Vtb_snake: compile.f src/*.sv src/*.svh tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_snake

test: obj_dir/Vtb_snake
	./obj_dir/Vtb_snake > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
+incdir+src
src/snake_pkg.sv
src/move_ctrl.sv
src/body_store.sv
src/food_spawner.sv
src/frame_render.sv
src/snake_top.sv
tests/snake_checker.sv
tests/tb_snake.sv

//--- src/body_store.sv
`timescale 1ns/1ps
`include "snake_config.svh"

module body_store (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     step,
    input  logic                     grow,
    input  snake_pkg::dir_e          dir,
    input  snake_pkg::cell_idx_t     probe_idx,
    output logic                     blocked,
    output logic [`SNAKE_CELLS-1:0] occ
);

    // each body cell points at the next cell toward the head
    snake_pkg::dir_e      ptr [`SNAKE_CELLS];
    snake_pkg::cell_idx_t head_idx;
    snake_pkg::cell_idx_t tail_idx;
    snake_pkg::cell_idx_t tail_next;
    logic                 tail_leaves;

    // ------------------------------
    // collision test
    // ------------------------------

    // without growth the tail cell is free again by the step edge
    assign tail_leaves = !grow && (probe_idx == tail_idx);
    assign blocked     = occ[probe_idx] && !tail_leaves;

    // follow the tail pointer one cell
    always_comb begin
        case (ptr[tail_idx])
            snake_pkg::UP: begin
                tail_next = tail_idx - snake_pkg::cell_idx_t'(`SNAKE_SIDE);
            end
            snake_pkg::RIGHT: begin
                tail_next = tail_idx + 6'd1;
            end
            snake_pkg::DOWN: begin
                tail_next = tail_idx + snake_pkg::cell_idx_t'(`SNAKE_SIDE);
            end
            default: begin
                tail_next = tail_idx - 6'd1;
            end
        endcase
    end

    // ------------------------------
    // body update
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SNAKE_CELLS; i++) begin
                ptr[i] <= snake_pkg::UP;
            end
            ptr[`SNAKE_START_TAIL] <= snake_pkg::RIGHT;
            occ                    <= '0;
            occ[`SNAKE_START_HEAD] <= 1'b1;
            occ[`SNAKE_START_TAIL] <= 1'b1;
            head_idx               <= snake_pkg::cell_idx_t'(`SNAKE_START_HEAD);
            tail_idx               <= snake_pkg::cell_idx_t'(`SNAKE_START_TAIL);
        end else if (step) begin
            // old head now leads toward the new head
            ptr[head_idx] <= dir;
            head_idx      <= probe_idx;

            // clear before set so a tail-follow step keeps the cell
            if (!grow) begin
                occ[tail_idx] <= 1'b0;
                tail_idx      <= tail_next;
            end
            occ[probe_idx] <= 1'b1;
        end
    end

    // the tail walks along the body and stays on an occupied cell
    a_tail_on_board: assert property (@(posedge clk) disable iff (rst)
        step && !grow |=> (tail_idx < `SNAKE_CELLS) && occ[tail_idx]);

endmodule

//--- src/food_spawner.sv
`timescale 1ns/1ps
`include "snake_config.svh"

module food_spawner (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     eat,
    input  logic [`SNAKE_CELLS-1:0] occ,
    output logic                     food_valid,
    output snake_pkg::cell_idx_t     food_idx,
    output logic                     scan_fail
);

    snake_pkg::spawn_state_e spawn_state;
    logic [5:0]              lfsr;
    snake_pkg::cell_idx_t    start_idx;
    snake_pkg::cell_idx_t    scan_idx;
    logic [5:0]              scan_cnt;
    logic                    cell_free;
    logic                    scan_last;

    // fold the LFSR value onto the board
    assign start_idx = (lfsr >= snake_pkg::cell_idx_t'(`SNAKE_CELLS)) ?
                       lfsr - snake_pkg::cell_idx_t'(`SNAKE_CELLS) : lfsr;
    assign cell_free = !occ[scan_idx];
    assign scan_last = (scan_cnt == 6'(`SNAKE_CELLS - 1));

    // maximal length taps, never reaches zero
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `SNAKE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
        end
    end

    // ------------------------------
    // scan FSM, one cell per cycle
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            spawn_state <= snake_pkg::SEED;
            food_valid  <= 1'b0;
            scan_fail   <= 1'b0;
            scan_idx    <= '0;
            scan_cnt    <= '0;
        end else begin
            scan_fail <= 1'b0;
            if (eat) begin
                food_valid <= 1'b0;
            end
            case (spawn_state)
                snake_pkg::SEED: begin
                    if (!food_valid) begin
                        scan_idx    <= start_idx;
                        scan_cnt    <= '0;
                        spawn_state <= snake_pkg::SCAN;
                    end
                end
                snake_pkg::SCAN: begin
                    if (cell_free) begin
                        food_valid  <= 1'b1;
                        spawn_state <= snake_pkg::SEED;
                    end else if (scan_last) begin
                        // whole board taken
                        scan_fail   <= 1'b1;
                        spawn_state <= snake_pkg::HOLD;
                    end else begin
                        scan_cnt <= scan_cnt + 6'd1;
                        if (scan_idx == snake_pkg::cell_idx_t'(`SNAKE_CELLS - 1)) begin
                            scan_idx <= '0;
                        end else begin
                            scan_idx <= scan_idx + 6'd1;
                        end
                    end
                end
                default: begin
                    spawn_state <= snake_pkg::HOLD;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (spawn_state == snake_pkg::SCAN && cell_free) begin
            food_idx <= scan_idx;
        end
    end

    a_food_on_free_cell: assert property (@(posedge clk) disable iff (rst)
        $rose(food_valid) |-> !occ[food_idx]);

endmodule

//--- src/frame_render.sv
`timescale 1ns/1ps
`include "snake_config.svh"

module frame_render (
    input  logic [`SNAKE_CELLS-1:0] occ,
    input  logic                     food_valid,
    input  snake_pkg::cell_idx_t     food_idx,
    output logic [`SNAKE_SIDE-1:0]  row0,
    output logic [`SNAKE_SIDE-1:0]  row1,
    output logic [`SNAKE_SIDE-1:0]  row2,
    output logic [`SNAKE_SIDE-1:0]  row3,
    output logic [`SNAKE_SIDE-1:0]  row4,
    output logic [`SNAKE_SIDE-1:0]  row5
);

    snake_pkg::coord_t      food_r;
    snake_pkg::coord_t      food_c;
    logic [`SNAKE_SIDE-1:0] col_mask;
    logic [`SNAKE_SIDE-1:0] rows [`SNAKE_SIDE];

    // food position as row and one-hot column
    always_comb begin
        food_r   = snake_pkg::coord_t'(food_idx / `SNAKE_SIDE);
        food_c   = snake_pkg::coord_t'(food_idx % `SNAKE_SIDE);
        col_mask = `SNAKE_SIDE'(1) << food_c;
    end

    // bit c of row r is cell r * 6 + c
    always_comb begin
        for (int r = 0; r < `SNAKE_SIDE; r++) begin
            rows[r] = occ[r*`SNAKE_SIDE +: `SNAKE_SIDE];
            if (food_valid && food_r == r) begin
                rows[r] = rows[r] | col_mask;
            end
        end
    end

    assign row0 = rows[0];
    assign row1 = rows[1];
    assign row2 = rows[2];
    assign row3 = rows[3];
    assign row4 = rows[4];
    assign row5 = rows[5];

endmodule

//--- src/move_ctrl.sv
`timescale 1ns/1ps
`include "snake_config.svh"

module move_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 up,
    input  logic                 down,
    input  logic                 left,
    input  logic                 right,
    input  logic                 blocked,
    input  logic                 food_valid,
    input  snake_pkg::cell_idx_t food_idx,
    input  logic                 scan_fail,
    output logic                 step,
    output logic                 grow,
    output logic                 eat,
    output snake_pkg::dir_e      dir,
    output snake_pkg::cell_idx_t probe_idx,
    output logic                 game_over
);

    snake_pkg::game_state_e game_state;
    snake_pkg::coord_t      head_r;
    snake_pkg::coord_t      head_c;
    snake_pkg::coord_t      next_r;
    snake_pkg::coord_t      next_c;
    logic                   wall_hit;

    // ------------------------------
    // next head cell and wall check
    // ------------------------------
    always_comb begin
        next_r   = head_r;
        next_c   = head_c;
        wall_hit = 1'b0;
        case (dir)
            snake_pkg::UP: begin
                if (head_r == '0) begin
                    wall_hit = 1'b1;
                end else begin
                    next_r = head_r - 3'd1;
                end
            end
            snake_pkg::RIGHT: begin
                if (head_c == snake_pkg::coord_t'(`SNAKE_SIDE - 1)) begin
                    wall_hit = 1'b1;
                end else begin
                    next_c = head_c + 3'd1;
                end
            end
            snake_pkg::DOWN: begin
                if (head_r == snake_pkg::coord_t'(`SNAKE_SIDE - 1)) begin
                    wall_hit = 1'b1;
                end else begin
                    next_r = head_r + 3'd1;
                end
            end
            default: begin
                if (head_c == '0) begin
                    wall_hit = 1'b1;
                end else begin
                    next_c = head_c - 3'd1;
                end
            end
        endcase
    end

    assign probe_idx = {3'b000, next_r} * snake_pkg::cell_idx_t'(`SNAKE_SIDE) + {3'b000, next_c};

    // the move eats when the head lands on the food
    assign grow      = food_valid && (probe_idx == food_idx);
    assign step      = (game_state == snake_pkg::RUN) && !wall_hit && !blocked;
    assign eat       = step && grow;
    assign game_over = (game_state == snake_pkg::OVER);

    // ------------------------------
    // game FSM, steering, head
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= snake_pkg::SPAWN;
            dir        <= snake_pkg::RIGHT;
            head_r     <= snake_pkg::coord_t'(`SNAKE_START_HEAD / `SNAKE_SIDE);
            head_c     <= snake_pkg::coord_t'(`SNAKE_START_HEAD % `SNAKE_SIDE);
        end else begin
            case (game_state)
                snake_pkg::RUN: begin
                    // priority up, right, down, left and no reversal
                    if (up && dir != snake_pkg::DOWN) begin
                        dir <= snake_pkg::UP;
                    end else if (right && dir != snake_pkg::LEFT) begin
                        dir <= snake_pkg::RIGHT;
                    end else if (down && dir != snake_pkg::UP) begin
                        dir <= snake_pkg::DOWN;
                    end else if (left && dir != snake_pkg::RIGHT) begin
                        dir <= snake_pkg::LEFT;
                    end

                    if (step) begin
                        head_r <= next_r;
                        head_c <= next_c;
                        if (grow) begin
                            game_state <= snake_pkg::SPAWN;
                        end
                    end else begin
                        game_state <= snake_pkg::OVER;
                    end
                end
                snake_pkg::SPAWN: begin
                    if (scan_fail) begin
                        game_state <= snake_pkg::OVER;
                    end else if (food_valid) begin
                        game_state <= snake_pkg::RUN;
                    end
                end
                default: begin
                    // stuck here until reset
                    game_state <= snake_pkg::OVER;
                end
            endcase
        end
    end

    // food stays on the board for as long as the snake moves
    a_step_with_food: assert property (@(posedge clk) disable iff (rst)
        step |-> food_valid);

endmodule

//--- src/snake_config.svh
`ifndef SNAKE_CONFIG_SVH
`define SNAKE_CONFIG_SVH

// ------------------------------
// board geometry
// ------------------------------

// cells per row and per column
`define SNAKE_SIDE 6

// whole board, indexed row * side + column
`define SNAKE_CELLS 36

// ------------------------------
// power-up contents
// ------------------------------

// head at row 2 column 3
`define SNAKE_START_HEAD 15

// tail just left of the head
`define SNAKE_START_TAIL 14

// any non-zero value works for the food LFSR
`define SNAKE_LFSR_SEED 6'b100111

`endif

//--- src/snake_pkg.sv
package snake_pkg;

    // one board cell, row * 6 + column
    typedef logic [5:0] cell_idx_t;

    // row or column on the board
    typedef logic [2:0] coord_t;

    // heading of the head, also stored per body cell
    typedef enum logic [1:0] {
        UP    = 2'd0,
        RIGHT = 2'd1,
        DOWN  = 2'd2,
        LEFT  = 2'd3
    } dir_e;

    // main game FSM
    typedef enum logic [1:0] {
        RUN   = 2'd0,
        SPAWN = 2'd1,
        OVER  = 2'd2
    } game_state_e;

    // food placement FSM
    typedef enum logic [1:0] {
        SEED = 2'd0,
        SCAN = 2'd1,
        HOLD = 2'd2
    } spawn_state_e;

endpackage

//--- src/snake_top.sv
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    up,
    input  logic                    down,
    input  logic                    left,
    input  logic                    right,
    output logic [`SNAKE_SIDE-1:0] row0,
    output logic [`SNAKE_SIDE-1:0] row1,
    output logic [`SNAKE_SIDE-1:0] row2,
    output logic [`SNAKE_SIDE-1:0] row3,
    output logic [`SNAKE_SIDE-1:0] row4,
    output logic [`SNAKE_SIDE-1:0] row5,
    output logic                    game_over
);

    // controller to body store
    logic                     step;
    logic                     grow;
    logic                     eat;
    snake_pkg::dir_e          dir;
    snake_pkg::cell_idx_t     probe_idx;
    logic                     blocked;

    // shared board and food
    logic [`SNAKE_CELLS-1:0] occ;
    logic                     food_valid;
    snake_pkg::cell_idx_t     food_idx;
    logic                     scan_fail;

    // ------------------------------
    // instances
    // ------------------------------
    move_ctrl u_move_ctrl (
        .clk        (clk),
        .rst        (rst),
        .up         (up),
        .down       (down),
        .left       (left),
        .right      (right),
        .blocked    (blocked),
        .food_valid (food_valid),
        .food_idx   (food_idx),
        .scan_fail  (scan_fail),
        .step       (step),
        .grow       (grow),
        .eat        (eat),
        .dir        (dir),
        .probe_idx  (probe_idx),
        .game_over  (game_over)
    );

    body_store u_body_store (
        .clk       (clk),
        .rst       (rst),
        .step      (step),
        .grow      (grow),
        .dir       (dir),
        .probe_idx (probe_idx),
        .blocked   (blocked),
        .occ       (occ)
    );

    food_spawner u_food_spawner (
        .clk        (clk),
        .rst        (rst),
        .eat        (eat),
        .occ        (occ),
        .food_valid (food_valid),
        .food_idx   (food_idx),
        .scan_fail  (scan_fail)
    );

    frame_render u_frame_render (
        .occ        (occ),
        .food_valid (food_valid),
        .food_idx   (food_idx),
        .row0       (row0),
        .row1       (row1),
        .row2       (row2),
        .row3       (row3),
        .row4       (row4),
        .row5       (row5)
    );

endmodule

//--- tests/snake_checker.sv
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic       up,
    input  logic       down,
    input  logic       left,
    input  logic       right,
    input  logic [5:0] row0,
    input  logic [5:0] row1,
    input  logic [5:0] row2,
    input  logic [5:0] row3,
    input  logic [5:0] row4,
    input  logic [5:0] row5,
    input  logic       game_over,
    output int         err_count
);

    // ------------------------------
    // game model state
    // ------------------------------
    snake_pkg::game_state_e  m_state;
    snake_pkg::dir_e         m_dir;
    int                      m_head_r;
    int                      m_head_c;
    int                      body_q[$];
    logic [35:0]             m_occ;
    logic [5:0]              m_lfsr;
    snake_pkg::spawn_state_e m_spawn;
    int                      m_scan_idx;
    int                      m_scan_cnt;
    logic                    m_food_valid;
    int                      m_food_idx;
    logic                    m_scan_fail;
    logic                    model_ready = 1'b0;

    initial err_count = 0;

    function automatic void model_reset();
        m_state      = snake_pkg::SPAWN;
        m_dir        = snake_pkg::RIGHT;
        m_head_r     = `SNAKE_START_HEAD / `SNAKE_SIDE;
        m_head_c     = `SNAKE_START_HEAD % `SNAKE_SIDE;
        body_q       = {`SNAKE_START_TAIL, `SNAKE_START_HEAD};
        m_occ        = '0;
        m_occ[`SNAKE_START_TAIL] = 1'b1;
        m_occ[`SNAKE_START_HEAD] = 1'b1;
        m_lfsr       = `SNAKE_LFSR_SEED;
        m_spawn      = snake_pkg::SEED;
        m_scan_idx   = 0;
        m_scan_cnt   = 0;
        m_food_valid = 1'b0;
        m_food_idx   = 0;
        m_scan_fail  = 1'b0;
    endfunction

    // one clock of the whole game, all decisions taken on old values
    function automatic void model_step(input logic u, input logic d, input logic l,
                                       input logic r);
        int   nr;
        int   nc;
        int   probe;
        int   start;
        logic wall;
        logic grow;
        logic blocked;
        logic step;
        logic old_fv;
        logic old_fail;
        logic [35:0] old_occ;
        nr       = m_head_r;
        nc       = m_head_c;
        wall     = 1'b0;
        old_fv   = m_food_valid;
        old_occ  = m_occ;
        // controller sees the registered pulse
        old_fail = m_scan_fail;
        case (m_dir)
            snake_pkg::UP: begin
                if (nr == 0) wall = 1'b1;
                else nr = nr - 1;
            end
            snake_pkg::RIGHT: begin
                if (nc == 5) wall = 1'b1;
                else nc = nc + 1;
            end
            snake_pkg::DOWN: begin
                if (nr == 5) wall = 1'b1;
                else nr = nr + 1;
            end
            default: begin
                if (nc == 0) wall = 1'b1;
                else nc = nc - 1;
            end
        endcase
        probe   = nr * 6 + nc;
        grow    = old_fv && (probe == m_food_idx);
        blocked = old_occ[probe] && !(!grow && probe == body_q[0]);
        step    = (m_state == snake_pkg::RUN) && !wall && !blocked;

        // food placement
        start = (m_lfsr >= 36) ? m_lfsr - 36 : m_lfsr;
        m_scan_fail = 1'b0;
        if (step && grow) m_food_valid = 1'b0;
        case (m_spawn)
            snake_pkg::SEED: begin
                if (!old_fv) begin
                    m_scan_idx = start;
                    m_scan_cnt = 0;
                    m_spawn    = snake_pkg::SCAN;
                end
            end
            snake_pkg::SCAN: begin
                if (!old_occ[m_scan_idx]) begin
                    m_food_valid = 1'b1;
                    m_food_idx   = m_scan_idx;
                    m_spawn      = snake_pkg::SEED;
                end else if (m_scan_cnt == 35) begin
                    m_scan_fail = 1'b1;
                    m_spawn     = snake_pkg::HOLD;
                end else begin
                    m_scan_cnt = m_scan_cnt + 1;
                    m_scan_idx = (m_scan_idx == 35) ? 0 : m_scan_idx + 1;
                end
            end
            default: ;
        endcase
        m_lfsr = {m_lfsr[4:0], m_lfsr[5] ^ m_lfsr[4]};

        // game state, steering and body
        case (m_state)
            snake_pkg::RUN: begin
                if (u && m_dir != snake_pkg::DOWN) m_dir = snake_pkg::UP;
                else if (r && m_dir != snake_pkg::LEFT) m_dir = snake_pkg::RIGHT;
                else if (d && m_dir != snake_pkg::UP) m_dir = snake_pkg::DOWN;
                else if (l && m_dir != snake_pkg::RIGHT) m_dir = snake_pkg::LEFT;
                if (step) begin
                    m_head_r = nr;
                    m_head_c = nc;
                    if (!grow) begin
                        m_occ[body_q[0]] = 1'b0;
                        void'(body_q.pop_front());
                    end
                    m_occ[probe] = 1'b1;
                    body_q.push_back(probe);
                    if (grow) m_state = snake_pkg::SPAWN;
                end else begin
                    m_state = snake_pkg::OVER;
                end
            end
            snake_pkg::SPAWN: begin
                if (old_fail) m_state = snake_pkg::OVER;
                else if (old_fv) m_state = snake_pkg::RUN;
            end
            default: ;
        endcase
    endfunction

    function automatic logic [5:0] exp_row(input int r);
        logic [5:0] v;
        v = m_occ[r*6 +: 6];
        if (m_food_valid && (m_food_idx / 6) == r) v[m_food_idx % 6] = 1'b1;
        return v;
    endfunction

    function automatic void check_value(input string name, input logic [5:0] act,
                                        input logic [5:0] exp);
        if (act !== exp) begin
            $display("ERROR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
            err_count = err_count + 1;
        end
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            model_reset();
            model_ready = 1'b1;
        end else if (model_ready) begin
            model_step(up, down, left, right);
        end
    end

    // outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (model_ready) begin
            check_value("row0", row0, exp_row(0));
            check_value("row1", row1, exp_row(1));
            check_value("row2", row2, exp_row(2));
            check_value("row3", row3, exp_row(3));
            check_value("row4", row4, exp_row(4));
            check_value("row5", row5, exp_row(5));
            check_value("game_over", {5'd0, game_over},
                        {5'd0, m_state == snake_pkg::OVER});
        end
    end

endmodule

//--- tests/tb_snake.sv
`timescale 1ns/1ps

module tb_snake;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       up = 1'b0;
    logic       down = 1'b0;
    logic       left = 1'b0;
    logic       right = 1'b0;
    logic [5:0] row0, row1, row2, row3, row4, row5;
    logic       game_over;
    int         err_count;
    int         n_pass = 0;
    int         n_fail = 0;
    int         err_base;
    logic       test_ok;
    logic [31:0] rng = 32'd20;

    always #5 clk = ~clk;

    snake_top UUT (
        .clk(clk), .rst(rst), .up(up), .down(down), .left(left), .right(right),
        .row0(row0), .row1(row1), .row2(row2), .row3(row3), .row4(row4), .row5(row5),
        .game_over(game_over)
    );

    snake_checker chk (
        .clk(clk), .rst(rst), .up(up), .down(down), .left(left), .right(right),
        .row0(row0), .row1(row1), .row2(row2), .row3(row3), .row4(row4), .row5(row5),
        .game_over(game_over), .err_count(err_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int lit_cells();
        return $countones({row0, row1, row2, row3, row4, row5});
    endfunction

    task automatic drive_keys(input logic [3:0] k);
        {up, right, down, left} = k;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        drive_keys(4'b0000);
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic start_test();
        err_base = err_count;
        test_ok  = 1'b1;
    endtask

    task automatic end_test(input string name);
        if (test_ok && err_count == err_base) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail", name);
        end
    endtask

    // food shows as one lit cell more than the body
    task automatic wait_food(input int limit);
        int n;
        n = 0;
        while (lit_cells() != chk.body_q.size() + 1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (lit_cells() != chk.body_q.size() + 1) begin
            $display("timeout: no food appeared within %0d cycles", limit);
            test_ok = 1'b0;
        end
    endtask

    // head toward the food, sidestep when that would be a reversal
    function automatic snake_pkg::dir_e toward_food();
        snake_pkg::dir_e want;
        int hr;
        int hc;
        int fr;
        int fc;
        hr = chk.m_head_r;
        hc = chk.m_head_c;
        fr = chk.m_food_idx / 6;
        fc = chk.m_food_idx % 6;
        // a key only turns the step after the coming one
        if (chk.m_state == snake_pkg::RUN) begin
            case (chk.m_dir)
                snake_pkg::UP:    hr = hr - 1;
                snake_pkg::RIGHT: hc = hc + 1;
                snake_pkg::DOWN:  hr = hr + 1;
                default:          hc = hc - 1;
            endcase
        end
        if (fr < hr) want = snake_pkg::UP;
        else if (fr > hr) want = snake_pkg::DOWN;
        else if (fc > hc) want = snake_pkg::RIGHT;
        else want = snake_pkg::LEFT;
        if ((want ^ 2'd2) == chk.m_dir) begin
            if (chk.m_dir == snake_pkg::LEFT || chk.m_dir == snake_pkg::RIGHT)
                want = (hr < 3) ? snake_pkg::DOWN : snake_pkg::UP;
            else
                want = (hc < 3) ? snake_pkg::RIGHT : snake_pkg::LEFT;
        end
        return want;
    endfunction

    // random steering mostly chases the food so the body grows long
    task automatic wait_game_over(input int limit, input logic random_keys);
        int n;
        n = 0;
        while (!game_over && n < limit) begin
            if (random_keys) begin
                rng = xorshift(rng);
                if (rng[10:8] == 3'd0) begin
                    drive_keys(rng[3:0] & rng[7:4]);
                end else begin
                    drive_keys(4'b1000 >> toward_food());
                end
            end
            @(negedge clk);
            n++;
        end
        drive_keys(4'b0000);
        if (!game_over) begin
            $display("timeout: game never ended within %0d cycles", limit);
            test_ok = 1'b0;
        end
    endtask

    task automatic chase_food(output logic grew);
        int n;
        int len0;
        snake_pkg::dir_e w;
        n    = 0;
        len0 = chk.body_q.size();
        grew = 1'b0;
        while (!grew && !game_over && n < 200) begin
            w = toward_food();
            drive_keys(4'b1000 >> w);
            @(negedge clk);
            n++;
            grew = (chk.body_q.size() == len0 + 1);
        end
        drive_keys(4'b0000);
    endtask

    initial begin
        logic [35:0] frozen;
        logic        grew;
        int          n;

        // ------------------------------
        // reset view and first food
        // ------------------------------
        start_test();
        apply_reset();
        if (row2 !== 6'h0c) begin
            $display("ERROR row2 expected 0x0c actual 0x%h", row2);
            test_ok = 1'b0;
        end
        if ((row0 | row1 | row3 | row4 | row5) !== 6'h00) begin
            $display("cells outside row 2 are lit after reset");
            test_ok = 1'b0;
        end
        wait_food(37);
        if (game_over !== 1'b0) begin
            $display("ERROR game_over expected 0x0 actual 0x%h", game_over);
            test_ok = 1'b0;
        end
        end_test("reset_and_food");

        // straight run into the right wall
        start_test();
        wait_game_over(30, 1'b0);
        frozen = {row0, row1, row2, row3, row4, row5};
        repeat (10) @(negedge clk);
        if ({row0, row1, row2, row3, row4, row5} !== frozen || !game_over) begin
            $display("board changed after game over");
            test_ok = 1'b0;
        end
        end_test("wall_hit");

        // ------------------------------
        // steering
        // ------------------------------
        start_test();
        apply_reset();
        wait_food(37);
        n = 0;
        while (chk.m_state != snake_pkg::RUN && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (chk.m_state != snake_pkg::RUN) begin
            $display("timeout: game did not start running");
            test_ok = 1'b0;
        end
        left = 1'b1;
        @(negedge clk);
        left = 1'b0;
        down = 1'b1;
        @(negedge clk);
        down = 1'b0;
        repeat (2) @(negedge clk);
        // left ignored, one more step right, then two steps down in column 5
        if (row3 !== 6'h20) begin
            $display("ERROR row3 expected 0x20 actual 0x%h", row3);
            test_ok = 1'b0;
        end
        if (row4 !== 6'h20) begin
            $display("ERROR row4 expected 0x20 actual 0x%h", row4);
            test_ok = 1'b0;
        end
        end_test("steering");

        // growth toward the food
        start_test();
        apply_reset();
        wait_food(37);
        chase_food(grew);
        if (!grew) begin
            $display("snake never reached the food");
            test_ok = 1'b0;
        end else begin
            // two start cells plus one, old food gone
            if (lit_cells() != 3) begin
                $display("ERROR lit_cells expected 0x3 actual 0x%h", lit_cells());
                test_ok = 1'b0;
            end
            wait_food(37);
        end
        end_test("growth");

        // random games against the model
        start_test();
        for (int g = 0; g < 8; g++) begin
            apply_reset();
            wait_game_over(4000, 1'b1);
            repeat (3) @(negedge clk);
        end
        end_test("random_games");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
